// ==== design/cacheGeomPkg.sv ====
//////////////////////////////////////////////////////////////
// Cache geometry package
// Line size, offset width and the address word union that
// gives both a raw and a line/offset view of one address
//////////////////////////////////////////////////////////////
`default_nettype none

package cacheGeomPkg;

    localparam int ADDR_WIDTH   = 32;
    localparam int LINE_WORDS   = 8;                       // 32-bit words per line
    localparam int OFFSET_WIDTH = $clog2(LINE_WORDS * 4);  // Byte offset inside a line

    // One address word, decoded either as a plain word or as line + offset
    typedef union packed {
        logic [ADDR_WIDTH-1:0] raw;
        struct packed {
            logic [ADDR_WIDTH-OFFSET_WIDTH-1:0] lineAddr;
            logic [OFFSET_WIDTH-1:0]            lineOffset;
        } line;
    } addrWord_u;

endpackage

`default_nettype wire

// ==== design/pipeCtrlPkg.sv ====
//////////////////////////////////////////////////////////////
// Pipeline control package
// Stage count, stage indices and token tag width
//////////////////////////////////////////////////////////////
`default_nettype none

package pipeCtrlPkg;

    localparam int NUM_STAGES = 7;

    // Bit positions in the per-stage write and flush vectors
    localparam int STG_PREIF = 0;
    localparam int STG_IF    = 1;
    localparam int STG_ID    = 2;
    localparam int STG_EXE   = 3;
    localparam int STG_MEM   = 4;
    localparam int STG_MEM2  = 5;
    localparam int STG_WB    = 6;

    localparam int TAG_WIDTH = 8;  // Tags wrap modulo 256

endpackage

`default_nettype wire

// ==== design/lineConflict.sv ====
//////////////////////////////////////////////////////////////
// Load/store line conflict check
// Flags a cached MEM access that hits the same cache line as
// a cached store still sitting in MEM2 or WB
//////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module lineConflict (
    input  cacheGeomPkg::addrWord_u memAddr,
    input  logic                    memLoadStoreReq,
    input  logic                    memCached,
    input  cacheGeomPkg::addrWord_u mem2Addr,
    input  logic                    mem2StoreReq,
    input  logic                    mem2Cached,
    input  cacheGeomPkg::addrWord_u wbAddr,
    input  logic                    wbStoreReq,
    input  logic                    wbCached,
    output logic                    loadStoreConflict
);

    logic memAccess;    // Cached load or store in MEM
    logic mem2Store;
    logic wbStore;
    logic mem2SameLine;
    logic wbSameLine;

    assign memAccess = memLoadStoreReq & memCached;
    assign mem2Store = mem2StoreReq & mem2Cached;
    assign wbStore   = wbStoreReq & wbCached;

    // Offset bits are ignored, only the line address matters
    assign mem2SameLine = (memAddr.line.lineAddr == mem2Addr.line.lineAddr);
    assign wbSameLine   = (memAddr.line.lineAddr == wbAddr.line.lineAddr);

    // MEM waits until older stores to its line have drained
    assign loadStoreConflict = memAccess &
                               ((mem2Store & mem2SameLine) | (wbStore & wbSameLine));

endmodule

`default_nettype wire

// ==== design/hazardControl.sv ====
//////////////////////////////////////////////////////////////
// Pipeline hazard control
// Fixed priority table from stall and redirect causes to the
// per-stage write/flush vectors, write-disable strobes and
// cache request, flush and stall levels
//////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module hazardControl (
    input  logic                               flushException,
    input  logic                               iTlbStall,
    input  logic                               dTlbStall,
    input  logic                               icacheBusy,
    input  logic                               dcacheBusy,
    input  logic                               loadStoreConflict,
    input  logic                               dataHazardStall,
    input  logic                               idImmJump,
    input  logic                               branchFailed,
    input  logic                               mulDivBusy,
    output logic [pipeCtrlPkg::NUM_STAGES-1:0] stageWr,
    output logic [pipeCtrlPkg::NUM_STAGES-1:0] stageFlush,
    output logic                               exeDisWr,  // Blocks HI/LO write in EXE
    output logic                               memDisWr,  // Blocks CP0 write in MEM
    output logic                               wbDisWr,
    output logic                               icacheFlush,
    output logic                               iReqValid,
    output logic                               dReqValid,
    output logic                               icacheStall,
    output logic                               dcacheStall
);

    import pipeCtrlPkg::*;

    logic iSideBusy;
    logic dSideBusy;

    assign iSideBusy = iTlbStall | icacheBusy;
    assign dSideBusy = dTlbStall | dcacheBusy;

    always_comb begin
        // Everything low unless the selected row raises it
        stageWr     = '0;
        stageFlush  = '0;
        exeDisWr    = 1'b0;
        memDisWr    = 1'b0;
        wbDisWr     = 1'b0;
        icacheFlush = 1'b0;
        iReqValid   = 1'b0;
        dReqValid   = 1'b0;
        icacheStall = 1'b0;
        dcacheStall = 1'b0;

        if (flushException) begin
            // Older instructions in MEM2/WB complete, younger ones are killed
            stageWr[STG_PREIF]   = 1'b1;
            stageWr[STG_MEM2]    = 1'b1;
            stageWr[STG_WB]      = 1'b1;
            stageFlush[STG_IF]   = 1'b1;
            stageFlush[STG_ID]   = 1'b1;
            stageFlush[STG_EXE]  = 1'b1;
            stageFlush[STG_MEM]  = 1'b1;
            exeDisWr             = 1'b1;
            memDisWr             = 1'b1;
            icacheFlush          = 1'b1;
        end else if (iSideBusy) begin
            memDisWr    = 1'b1;
            wbDisWr     = 1'b1;
            icacheStall = 1'b1;
            dcacheStall = 1'b1;
            dReqValid   = 1'b1;
        end else if (dSideBusy) begin
            memDisWr    = 1'b1;
            wbDisWr     = 1'b1;
            icacheStall = 1'b1;
            dcacheStall = 1'b1;
            iReqValid   = 1'b1;
        end else if (loadStoreConflict) begin
            // Let the store in WB drain, bubble into MEM2
            stageWr[STG_WB]      = 1'b1;
            stageFlush[STG_MEM2] = 1'b1;
            icacheStall          = 1'b1;
        end else if (dataHazardStall) begin
            stageWr[STG_MEM]     = 1'b1;
            stageWr[STG_MEM2]    = 1'b1;
            stageWr[STG_WB]      = 1'b1;
            stageFlush[STG_EXE]  = 1'b1;  // Bubble behind the stalled front end
            icacheStall          = 1'b1;
            iReqValid            = 1'b1;
            dReqValid            = 1'b1;
        end else if (idImmJump) begin
            stageWr            = '1;
            stageWr[STG_IF]    = 1'b0;
            stageFlush[STG_IF] = 1'b1;    // One wrong-path slot
            icacheFlush        = 1'b1;
            dReqValid          = 1'b1;
        end else if (branchFailed) begin
            stageWr[STG_PREIF] = 1'b1;
            stageWr[STG_EXE]   = 1'b1;
            stageWr[STG_MEM]   = 1'b1;
            stageWr[STG_MEM2]  = 1'b1;
            stageWr[STG_WB]    = 1'b1;
            stageFlush[STG_IF] = 1'b1;
            stageFlush[STG_ID] = 1'b1;
            icacheFlush        = 1'b1;
            dReqValid          = 1'b1;
        end else if (mulDivBusy) begin
            // Whole pipe frozen while the multiplier/divider runs
            exeDisWr    = 1'b1;
            memDisWr    = 1'b1;
            wbDisWr     = 1'b1;
            icacheStall = 1'b1;
            dcacheStall = 1'b1;
            iReqValid   = 1'b1;
            dReqValid   = 1'b1;
        end else begin
            stageWr   = '1;
            iReqValid = 1'b1;
            dReqValid = 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== design/stageTracker.sv ====
//////////////////////////////////////////////////////////////
// Stage occupancy tracker
// Moves numbered tokens through the seven stage registers
// under the write/flush controls and reports WB departures
//////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module stageTracker (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [pipeCtrlPkg::NUM_STAGES-1:0] stageWr,
    input  logic [pipeCtrlPkg::NUM_STAGES-1:0] stageFlush,
    output logic                               retireValid,
    output logic [pipeCtrlPkg::TAG_WIDTH-1:0]  retireTag
);

    import pipeCtrlPkg::*;

    logic [NUM_STAGES-1:0] stageValid;
    logic [TAG_WIDTH-1:0]  stageTag [NUM_STAGES];
    logic [TAG_WIDTH-1:0]  fetchCnt;   // Next tag to issue

    logic [NUM_STAGES-1:0] upValid;    // What each stage would load on a write
    logic [TAG_WIDTH-1:0]  upTag [NUM_STAGES];
    logic [NUM_STAGES-1:0] stageLoad;

    // PREIF is fed by the fetch counter, always with a valid token
    assign upValid = {stageValid[NUM_STAGES-2:0], 1'b1};

    always_comb begin
        upTag[STG_PREIF] = fetchCnt;
        for (int s = 1; s < NUM_STAGES; s++) begin
            upTag[s] = stageTag[s-1];
        end
    end

    assign stageLoad = stageWr & ~stageFlush;  // Flush wins over write

    always_ff @(posedge clk) begin
        if (rst) begin
            stageValid <= '0;
            fetchCnt   <= '0;
        end else begin
            for (int s = 0; s < NUM_STAGES; s++) begin
                if (stageFlush[s]) begin
                    stageValid[s] <= 1'b0;
                end else if (stageWr[s]) begin
                    stageValid[s] <= upValid[s];
                end
            end
            if (stageLoad[STG_PREIF]) begin
                fetchCnt <= fetchCnt + 1'b1;
            end
        end
    end

    // Tags only mean something where the valid bit is set
    always_ff @(posedge clk) begin
        for (int s = 0; s < NUM_STAGES; s++) begin
            if (stageLoad[s]) begin
                stageTag[s] <= upTag[s];
            end
        end
    end

    // A token leaves WB when WB takes the next one in
    assign retireValid = stageValid[STG_WB] & stageWr[STG_WB];
    assign retireTag   = stageTag[STG_WB];

endmodule

`default_nettype wire

// ==== design/pipelineControl.sv ====
//////////////////////////////////////////////////////////////
// Pipeline control slice, top level
// Line conflict check, priority table and stage tracker
//////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module pipelineControl (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 flushException,
    input  logic                                 iTlbStall,
    input  logic                                 dTlbStall,
    input  logic                                 icacheBusy,
    input  logic                                 dcacheBusy,
    input  logic                                 dataHazardStall,
    input  logic                                 idImmJump,
    input  logic                                 branchFailed,
    input  logic                                 mulDivBusy,
    input  logic [cacheGeomPkg::ADDR_WIDTH-1:0]  memAddr,
    input  logic                                 memLoadStoreReq,
    input  logic                                 memCached,
    input  logic [cacheGeomPkg::ADDR_WIDTH-1:0]  mem2Addr,
    input  logic                                 mem2StoreReq,
    input  logic                                 mem2Cached,
    input  logic [cacheGeomPkg::ADDR_WIDTH-1:0]  wbAddr,
    input  logic                                 wbStoreReq,
    input  logic                                 wbCached,
    output logic [pipeCtrlPkg::NUM_STAGES-1:0]   stageWr,
    output logic [pipeCtrlPkg::NUM_STAGES-1:0]   stageFlush,
    output logic                                 exeDisWr,
    output logic                                 memDisWr,
    output logic                                 wbDisWr,
    output logic                                 icacheFlush,
    output logic                                 iReqValid,
    output logic                                 dReqValid,
    output logic                                 icacheStall,
    output logic                                 dcacheStall,
    output logic                                 retireValid,
    output logic [pipeCtrlPkg::TAG_WIDTH-1:0]    retireTag
);

    logic loadStoreConflict;

    lineConflict uLineConflict (
        .memAddr           (memAddr),  // Raw word seen through the line view
        .memLoadStoreReq   (memLoadStoreReq),
        .memCached         (memCached),
        .mem2Addr          (mem2Addr),
        .mem2StoreReq      (mem2StoreReq),
        .mem2Cached        (mem2Cached),
        .wbAddr            (wbAddr),
        .wbStoreReq        (wbStoreReq),
        .wbCached          (wbCached),
        .loadStoreConflict (loadStoreConflict)
    );

    hazardControl uHazardControl (
        .flushException    (flushException),
        .iTlbStall         (iTlbStall),
        .dTlbStall         (dTlbStall),
        .icacheBusy        (icacheBusy),
        .dcacheBusy        (dcacheBusy),
        .loadStoreConflict (loadStoreConflict),
        .dataHazardStall   (dataHazardStall),
        .idImmJump         (idImmJump),
        .branchFailed      (branchFailed),
        .mulDivBusy        (mulDivBusy),
        .stageWr           (stageWr),
        .stageFlush        (stageFlush),
        .exeDisWr          (exeDisWr),
        .memDisWr          (memDisWr),
        .wbDisWr           (wbDisWr),
        .icacheFlush       (icacheFlush),
        .iReqValid         (iReqValid),
        .dReqValid         (dReqValid),
        .icacheStall       (icacheStall),
        .dcacheStall       (dcacheStall)
    );

    stageTracker uStageTracker (
        .clk         (clk),
        .rst         (rst),
        .stageWr     (stageWr),
        .stageFlush  (stageFlush),
        .retireValid (retireValid),
        .retireTag   (retireTag)
    );

endmodule

`default_nettype wire

// ==== testbench/pipelineControl_asserts.sv ====
//////////////////////////////////////////////////////////////
// Pipeline control checker
// Rebuilds the priority table and token order from the rules
// and holds the DUT to them with concurrent assertions
//////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module pipelineControlChecker (
    input logic                                clk,
    input logic                                rst,
    input logic                                flushException,
    input logic                                iTlbStall,
    input logic                                dTlbStall,
    input logic                                icacheBusy,
    input logic                                dcacheBusy,
    input logic                                dataHazardStall,
    input logic                                idImmJump,
    input logic                                branchFailed,
    input logic                                mulDivBusy,
    input logic [cacheGeomPkg::ADDR_WIDTH-1:0] memAddr,
    input logic                                memLoadStoreReq,
    input logic                                memCached,
    input logic [cacheGeomPkg::ADDR_WIDTH-1:0] mem2Addr,
    input logic                                mem2StoreReq,
    input logic                                mem2Cached,
    input logic [cacheGeomPkg::ADDR_WIDTH-1:0] wbAddr,
    input logic                                wbStoreReq,
    input logic                                wbCached,
    input logic [pipeCtrlPkg::NUM_STAGES-1:0]  stageWr,
    input logic [pipeCtrlPkg::NUM_STAGES-1:0]  stageFlush,
    input logic                                exeDisWr,
    input logic                                memDisWr,
    input logic                                wbDisWr,
    input logic                                icacheFlush,
    input logic                                iReqValid,
    input logic                                dReqValid,
    input logic                                icacheStall,
    input logic                                dcacheStall,
    input logic                                retireValid,
    input logic [pipeCtrlPkg::TAG_WIDTH-1:0]   retireTag
);

    import cacheGeomPkg::*;
    import pipeCtrlPkg::*;

    localparam int CTRL_BITS = 2 * NUM_STAGES + 8;

    logic [3:0]           curRow;      // 1 = exception ... 9 = normal
    logic                 expConflict;
    logic [CTRL_BITS-1:0] expCtrl;
    logic [CTRL_BITS-1:0] actCtrl;
    logic [TAG_WIDTH-1:0] issueCnt;    // Tokens loaded into PREIF
    logic [TAG_WIDTH-1:0] lastTag;
    logic                 lastSeen;
    logic [TAG_WIDTH-1:0] floorTag;    // Issue count at the last exception
    logic                 floorArmed;
    logic [1:0]           exemptLeft;  // Older tokens still allowed to retire
    logic [3:0]           normalRun;
    logic [3:0]           sinceReset;
    int                   assertFails = 0;

    // Expected {stageWr, stageFlush, exe/mem/wb disable, icacheFlush,
    // iReqValid, dReqValid, icacheStall, dcacheStall}, stage bits WB..PREIF
    function automatic logic [CTRL_BITS-1:0] rowControls(input logic [3:0] row);
        case (row)
            4'd1:    return {7'b1100001, 7'b0011110, 8'b1101_0000};
            4'd2:    return {7'b0000000, 7'b0000000, 8'b0110_0111};
            4'd3:    return {7'b0000000, 7'b0000000, 8'b0110_1011};
            4'd4:    return {7'b1000000, 7'b0100000, 8'b0000_0010};
            4'd5:    return {7'b1110000, 7'b0001000, 8'b0000_1110};
            4'd6:    return {7'b1111101, 7'b0000010, 8'b0001_0100};
            4'd7:    return {7'b1111001, 7'b0000110, 8'b0001_0100};
            4'd8:    return {7'b0000000, 7'b0000000, 8'b1110_1111};
            default: return {7'b1111111, 7'b0000000, 8'b0000_1100};
        endcase
    endfunction

    // Same line means equal bits above the byte offset
    assign expConflict = memLoadStoreReq & memCached &
        ((mem2StoreReq & mem2Cached &
          (memAddr[ADDR_WIDTH-1:OFFSET_WIDTH] == mem2Addr[ADDR_WIDTH-1:OFFSET_WIDTH])) |
         (wbStoreReq & wbCached &
          (memAddr[ADDR_WIDTH-1:OFFSET_WIDTH] == wbAddr[ADDR_WIDTH-1:OFFSET_WIDTH])));

    always_comb begin
        if (flushException)
            curRow = 4'd1;
        else if (iTlbStall | icacheBusy)
            curRow = 4'd2;
        else if (dTlbStall | dcacheBusy)
            curRow = 4'd3;
        else if (expConflict)
            curRow = 4'd4;
        else if (dataHazardStall)
            curRow = 4'd5;
        else if (idImmJump)
            curRow = 4'd6;
        else if (branchFailed)
            curRow = 4'd7;
        else if (mulDivBusy)
            curRow = 4'd8;
        else
            curRow = 4'd9;
    end

    assign expCtrl = rowControls(curRow);
    assign actCtrl = {stageWr, stageFlush, exeDisWr, memDisWr, wbDisWr, icacheFlush,
                      iReqValid, dReqValid, icacheStall, dcacheStall};

    always_ff @(posedge clk) begin
        if (rst) begin
            issueCnt   <= '0;
            lastSeen   <= 1'b0;
            floorArmed <= 1'b0;
            exemptLeft <= '0;
            normalRun  <= '0;
            sinceReset <= '0;
        end else begin
            if (expCtrl[CTRL_BITS-NUM_STAGES] & ~expCtrl[8])  // PREIF written, not flushed
                issueCnt <= issueCnt + 1'b1;
            if (retireValid) begin
                lastTag  <= retireTag;
                lastSeen <= 1'b1;
            end
            if (flushException) begin
                floorTag   <= issueCnt;
                floorArmed <= 1'b1;
                exemptLeft <= 2'd2;   // Old MEM and MEM2 tokens
            end else if (retireValid && exemptLeft != 2'd0)
                exemptLeft <= exemptLeft - 1'b1;
            else if (retireValid)
                floorArmed <= 1'b0;
            if (curRow != 4'd9)
                normalRun <= '0;
            else if (normalRun != 4'd15)
                normalRun <= normalRun + 1'b1;
            if (sinceReset != 4'd15)
                sinceReset <= sinceReset + 1'b1;
        end
    end

    ctrlRowMatch: assert property (@(posedge clk) actCtrl == expCtrl)
        else begin
            assertFails++;
            $error("ERROR %0t: controls %h, row %0d expects %h", $time,
                   $sampled(actCtrl), $sampled(curRow), $sampled(expCtrl));
        end

    resetQuiet: assert property (@(posedge clk) disable iff (rst)
        sinceReset < 4'd6 |-> !retireValid)
        else begin
            assertFails++;
            $error("ERROR %0t: retire %0d too soon after reset", $time,
                   $sampled(sinceReset));
        end

    retireOrder: assert property (@(posedge clk) disable iff (rst)
        retireValid && lastSeen |-> TAG_WIDTH'(retireTag - lastTag) != '0 &&
                                    TAG_WIDTH'(retireTag - lastTag) < 8'd128)
        else begin
            assertFails++;
            $error("ERROR %0t: tag %0d retired after %0d", $time,
                   $sampled(retireTag), $sampled(lastTag));
        end

    flushedStayDead: assert property (@(posedge clk) disable iff (rst)
        retireValid && floorArmed && exemptLeft == 2'd0 && !flushException |->
        TAG_WIDTH'(retireTag - floorTag) < 8'd128)
        else begin
            assertFails++;
            $error("ERROR %0t: flushed tag %0d retired, floor %0d", $time,
                   $sampled(retireTag), $sampled(floorTag));
        end

    // Tag tracks the issue count, so back-to-back hits are consecutive tags
    normalStream: assert property (@(posedge clk) disable iff (rst)
        curRow == 4'd9 && normalRun >= 4'd7 |->
        retireValid && retireTag == TAG_WIDTH'(issueCnt - 8'd7))
        else begin
            assertFails++;
            $error("ERROR %0t: stream retire %b tag %0d, expected %0d", $time,
                   $sampled(retireValid), $sampled(retireTag),
                   TAG_WIDTH'($sampled(issueCnt) - 8'd7));
        end

endmodule

bind pipelineControl pipelineControlChecker uCheck (.*);

`default_nettype wire

// ==== testbench/pipelineControlTb.sv ====
//////////////////////////////////////////////////////////////
// Pipeline control testbench
// Directed and random stall/redirect stimulus with a watchdog,
// the bound checker does the comparing
//////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module pipelineControlTb;

    import cacheGeomPkg::*;
    import pipeCtrlPkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 4;
    localparam int RAND_CYCLES  = 3000;
    localparam int STIM_CYCLES  = RESET_CYCLES + 20 + 9 * 5 + 12 + 36 * 2 + 2 + 7 * 2
                                  + RAND_CYCLES + 21;

    logic                  clk;
    logic                  rst;
    logic                  flushException;
    logic                  iTlbStall;
    logic                  dTlbStall;
    logic                  icacheBusy;
    logic                  dcacheBusy;
    logic                  dataHazardStall;
    logic                  idImmJump;
    logic                  branchFailed;
    logic                  mulDivBusy;
    logic [ADDR_WIDTH-1:0] memAddr;
    logic                  memLoadStoreReq;
    logic                  memCached;
    logic [ADDR_WIDTH-1:0] mem2Addr;
    logic                  mem2StoreReq;
    logic                  mem2Cached;
    logic [ADDR_WIDTH-1:0] wbAddr;
    logic                  wbStoreReq;
    logic                  wbCached;
    logic [NUM_STAGES-1:0] stageWr;
    logic [NUM_STAGES-1:0] stageFlush;
    logic                  exeDisWr;
    logic                  memDisWr;
    logic                  wbDisWr;
    logic                  icacheFlush;
    logic                  iReqValid;
    logic                  dReqValid;
    logic                  icacheStall;
    logic                  dcacheStall;
    logic                  retireValid;
    logic [TAG_WIDTH-1:0]  retireTag;

    pipelineControl uut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Bits {mulDiv, branch, jump, hazard, dcache, dTlb, icache, iTlb, exception}
    task automatic driveCauses(input logic [8:0] c);
        @(posedge clk);
        flushException  <= c[0];
        iTlbStall       <= c[1];
        icacheBusy      <= c[2];
        dTlbStall       <= c[3];
        dcacheBusy      <= c[4];
        dataHazardStall <= c[5];
        idImmJump       <= c[6];
        branchFailed    <= c[7];
        mulDivBusy      <= c[8];
    endtask

    task automatic runNormal(input int cycles);
        repeat (cycles) driveCauses('0);
    endtask

    // Flags {memReq, memCached, mem2Store, mem2Cached, wbStore, wbCached}
    task automatic driveMem(input logic [ADDR_WIDTH-1:0] mA, input logic [ADDR_WIDTH-1:0] m2A,
                            input logic [ADDR_WIDTH-1:0] wA, input logic [5:0] f);
        memAddr         <= mA;
        mem2Addr        <= m2A;
        wbAddr          <= wA;
        memLoadStoreReq <= f[5];
        memCached       <= f[4];
        mem2StoreReq    <= f[3];
        mem2Cached      <= f[2];
        wbStoreReq      <= f[1];
        wbCached        <= f[0];
    endtask

    task automatic lineCase(input logic [ADDR_WIDTH-1:0] mA, input logic [ADDR_WIDTH-1:0] m2A,
                            input logic [ADDR_WIDTH-1:0] wA, input logic [5:0] f);
        driveCauses('0);
        driveMem(mA, m2A, wA, f);
        driveCauses('0);
    endtask

    task automatic runRandom(input int cycles);
        logic [8:0] c;
        for (int n = 0; n < cycles; n++) begin
            for (int b = 0; b < 9; b++)
                c[b] = ($urandom % 32) == 0;   // Causes stay rare
            driveCauses(c);
            // Four lines only, so same-line hits happen now and then
            driveMem({25'h0, 2'($urandom), 5'($urandom)}, {25'h0, 2'($urandom), 5'($urandom)},
                     {25'h0, 2'($urandom), 5'($urandom)}, 6'($urandom));
        end
    endtask

    initial begin
        void'($urandom(68));
        rst = 1'b1;
        flushException = 1'b0;
        iTlbStall = 1'b0;
        dTlbStall = 1'b0;
        icacheBusy = 1'b0;
        dcacheBusy = 1'b0;
        dataHazardStall = 1'b0;
        idImmJump = 1'b0;
        branchFailed = 1'b0;
        mulDivBusy = 1'b0;
        memAddr = '0;
        memLoadStoreReq = 1'b0;
        memCached = 1'b0;
        mem2Addr = '0;
        mem2StoreReq = 1'b0;
        mem2Cached = 1'b0;
        wbAddr = '0;
        wbStoreReq = 1'b0;
        wbCached = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        runNormal(20);

        for (int i = 0; i < 9; i++) begin
            repeat (3) driveCauses(9'(1 << i));
            runNormal(2);
        end
        runNormal(12);
        for (int i = 0; i < 9; i++) begin
            for (int j = i + 1; j < 9; j++) begin
                driveCauses(9'((1 << i) | (1 << j)));
                driveCauses('0);
            end
        end
        driveCauses(9'b1_0010_0001);   // Exception over hazard and mul/div
        driveCauses('0);

        lineCase(32'h0000_1004, 32'h0000_101C, 32'h0000_8000, 6'b111100); // MEM2 same line
        lineCase(32'h0000_2010, 32'h0000_4000, 32'h0000_2000, 6'b110011); // WB same line
        lineCase(32'h0000_1004, 32'h0000_1024, 32'h0000_1040, 6'b111111);
        lineCase(32'h0000_1004, 32'h0000_1000, 32'h0000_1000, 6'b101111); // MEM uncached
        lineCase(32'h0000_1004, 32'h0000_1000, 32'h0000_1000, 6'b111010);
        lineCase(32'h0000_1004, 32'h0000_1000, 32'h0000_1000, 6'b110101); // No store
        lineCase(32'h0000_1004, 32'h0000_1000, 32'h0000_1000, 6'b011111);

        runRandom(RAND_CYCLES);
        driveMem('0, '0, '0, 6'b000000);
        runNormal(20);
        @(posedge clk);
        $display("Run complete, assertion failures: %0d", uut.uCheck.assertFails);
        if (uut.uCheck.assertFails == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

    // Watchdog sized from the stimulus length with margin
    initial begin
        #(CLK_PERIOD * (STIM_CYCLES + 200));
        $display("Watchdog timeout, stimulus did not finish within %0d cycles",
                 STIM_CYCLES + 200);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
design/cacheGeomPkg.sv
design/pipeCtrlPkg.sv
design/lineConflict.sv
design/hazardControl.sv
design/stageTracker.sv
design/pipelineControl.sv
testbench/pipelineControl_asserts.sv
testbench/pipelineControlTb.sv

// ==== Makefile ====
# Verilator build and run of the pipeline control testbench

SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := pipelineControlTb
FILELIST := verilog.f
OBJDIR   := obj_dir
LOG      := sim.log
# Let every assertion failure be counted instead of stopping at the first
RUNOPTS  := +verilator+error+limit+100000

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the simulation, fail unless it passes"
	@echo "  clean  remove build output and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) $(RUNOPTS) | tee $(LOG)
	@grep -qx "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
